/* hw/int_ctrl.sv */
//======================================================================
// Interrupt controller
// Pending latches, two-level priority, nesting and vector output
//======================================================================

`timescale 1ns/10ps

module int_ctrl (
    input  logic                clk,
    input  logic                reset_n,
    input  sfr_pkg::sfr_byte_t  ie_i,
    input  sfr_pkg::sfr_byte_t  ip_i,
    input  int_pkg::int_vec_t   src_pulse_i,
    input  logic                interrupt_return_i,
    output sfr_pkg::sfr_byte_t  int_addr_o,
    output logic                int_gen_o
);

    int_pkg::int_vec_t  pending;
    int_pkg::int_vec_t  enabled;
    int_pkg::int_vec_t  hi_req;
    int_pkg::int_vec_t  lo_req;
    int_pkg::int_vec_t  clr_mask;
    // Bit 1 high level, bit 0 low level
    logic [1:0]         in_service;
    logic [1:0]         svc_next;
    logic               hi_found;
    logic               lo_found;
    int_pkg::int_idx_t  hi_idx;
    int_pkg::int_idx_t  lo_idx;
    int_pkg::int_idx_t  issue_idx;
    logic               issue;
    logic               issue_hi;

    // Lowest set index, found flag in the MSB
    function automatic logic [int_pkg::INT_IDX_WIDTH : 0] first_set(int_pkg::int_vec_t vec);
        logic [int_pkg::INT_IDX_WIDTH : 0] result;
        result = '0;
        for (int i = int_pkg::NUM_OF_INT - 1; i >= 0; i--) begin
            if (vec[i]) result = {1'b1, int_pkg::int_idx_t'(i)};
        end
        return result;
    endfunction

    //==================================================================
    // Arbitration
    //==================================================================
    always_comb begin
        enabled = pending & ie_i[int_pkg::NUM_OF_INT - 1 : 0] &
                  {int_pkg::NUM_OF_INT{ie_i[sfr_pkg::IE_EA_BIT]}};
        hi_req  = enabled & ip_i[int_pkg::NUM_OF_INT - 1 : 0];
        lo_req  = enabled & ~ip_i[int_pkg::NUM_OF_INT - 1 : 0];
        {hi_found, hi_idx} = first_set(hi_req);
        {lo_found, lo_idx} = first_set(lo_req);
        // High level only blocked by high; low level needs nothing in service
        issue_hi  = hi_found && !in_service[1];
        issue     = issue_hi || (!hi_found && lo_found && (in_service == 2'b00));
        issue_idx = issue_hi ? hi_idx : lo_idx;
        clr_mask  = issue ? int_pkg::int_vec_t'(1) << issue_idx : '0;

        // Return drops the highest active level
        svc_next = in_service;
        if (interrupt_return_i) begin
            if (in_service[1]) svc_next[1] = 1'b0;
            else               svc_next[0] = 1'b0;
        end
        if (issue) svc_next[issue_hi] = 1'b1;
    end

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            pending    <= '0;
            in_service <= '0;
            int_gen_o  <= 1'b0;
            int_addr_o <= '0;
        end else begin
            // A new pulse wins over the clear
            pending    <= (pending & ~clr_mask) | src_pulse_i;
            in_service <= svc_next;
            int_gen_o  <= issue;
            // Address held until the next request
            if (issue) begin
                int_addr_o <= int_pkg::VECTOR_BASE +
                              int_pkg::VECTOR_STEP * sfr_pkg::sfr_byte_t'(issue_idx);
            end
        end
    end

endmodule : int_ctrl

/* hw/int_pkg.sv */
//======================================================================
// Interrupt package
// Source count, source order and vector addresses
//======================================================================

package int_pkg;

    localparam int NUM_OF_INT    = 4;
    localparam int INT_IDX_WIDTH = $clog2(NUM_OF_INT);

    // One bit per source
    typedef logic [NUM_OF_INT - 1 : 0]    int_vec_t;
    typedef logic [INT_IDX_WIDTH - 1 : 0] int_idx_t;

    //==================================================================
    // Source order, also the IE/IP bit of each source
    //==================================================================
    localparam int INT_EXT0   = 0;
    localparam int INT_TIMER0 = 1;
    localparam int INT_EXT1   = 2;
    localparam int INT_TIMER1 = 3;

    // Vector = base + step * source index
    localparam sfr_pkg::sfr_byte_t VECTOR_BASE = 8'h03;
    localparam sfr_pkg::sfr_byte_t VECTOR_STEP = 8'h08;

endpackage : int_pkg

/* hw/periph_top.sv */
//======================================================================
// Peripheral top
// SFR registers, two timers and interrupt controller on plain ports
//======================================================================

`timescale 1ns/10ps

module periph_top (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                rd_stb_i,
    input  sfr_pkg::sfr_byte_t  rd_adr_i,
    output sfr_pkg::sfr_byte_t  rd_dat_o,
    output logic                rd_ack_o,
    input  logic                wr_stb_i,
    input  logic                wr_we_i,
    input  sfr_pkg::sfr_byte_t  wr_adr_i,
    input  sfr_pkg::sfr_byte_t  wr_dat_i,
    output logic                wr_ack_o,
    input  logic [1:0]          intx_i,
    input  logic                timer_event_pulse_i,
    input  logic                interrupt_return_i,
    output sfr_pkg::sfr_byte_t  int_addr_o,
    output logic                int_gen_o,
    output logic                timer_pulse_o
);

    sfr_pkg::sfr_byte_t  ie_val;
    sfr_pkg::sfr_byte_t  ip_val;
    sfr_pkg::sfr_byte_t  tmod_val;
    sfr_pkg::sfr_byte_t  th_tl0_dat;
    sfr_pkg::sfr_byte_t  th_tl1_dat;
    logic [1:0]          timer_run;
    logic [1:0]          timer_ovf;
    logic [1:0]          ext_sync;
    logic [1:0]          ext_edge;
    int_pkg::int_vec_t   src_pulse;

    sfr_bus_if bus ();

    // No back-pressure
    assign rd_ack_o = rd_stb_i;
    assign wr_ack_o = wr_stb_i;

    assign bus.wr_stb = wr_stb_i;
    assign bus.wr_we  = wr_we_i;
    assign bus.wr_adr = wr_adr_i;
    assign bus.wr_dat = wr_dat_i;
    assign bus.rd_adr = rd_adr_i;

    sfr_core_regs u_regs (
        .clk, .reset_n, .bus, .intx_i,
        .timer_ovf_i (timer_ovf), .th_tl0_dat_i (th_tl0_dat), .th_tl1_dat_i (th_tl1_dat),
        .rd_dat_o, .ie_o (ie_val), .ip_o (ip_val), .tmod_o (tmod_val),
        .timer_run_o (timer_run), .ext_sync_o (ext_sync), .ext_edge_o (ext_edge)
    );

    // Timer 0 drives the toggle pin
    timer_8051 #(.TIMER_ID (0)) u_timer0 (
        .clk, .reset_n, .bus, .tmod_i (tmod_val), .run_i (timer_run[0]),
        .gate_level_i (ext_sync[0]), .event_pulse_i (timer_event_pulse_i),
        .rd_dat_o (th_tl0_dat), .ovf_o (timer_ovf[0]), .timer_pulse_o
    );

    timer_8051 #(.TIMER_ID (1)) u_timer1 (
        .clk, .reset_n, .bus, .tmod_i (tmod_val), .run_i (timer_run[1]),
        .gate_level_i (ext_sync[1]), .event_pulse_i (timer_event_pulse_i),
        .rd_dat_o (th_tl1_dat), .ovf_o (timer_ovf[1]), .timer_pulse_o ()
    );

    // Source vector in controller order
    always_comb begin
        src_pulse                      = '0;
        src_pulse[int_pkg::INT_EXT0]   = ext_edge[0];
        src_pulse[int_pkg::INT_TIMER0] = timer_ovf[0];
        src_pulse[int_pkg::INT_EXT1]   = ext_edge[1];
        src_pulse[int_pkg::INT_TIMER1] = timer_ovf[1];
    end

    int_ctrl u_int_ctrl (
        .clk, .reset_n, .ie_i (ie_val), .ip_i (ip_val), .src_pulse_i (src_pulse),
        .interrupt_return_i, .int_addr_o, .int_gen_o
    );

endmodule : periph_top

/* hw/sfr_bus_if.sv */
//======================================================================
// SFR bus interface
// Write port and read address from the top level to the registers
//======================================================================

`timescale 1ns/10ps

interface sfr_bus_if;

    logic                 wr_stb;
    logic                 wr_we;
    sfr_pkg::sfr_byte_t   wr_adr;
    sfr_pkg::sfr_byte_t   wr_dat;
    // Read data goes back on plain ports
    sfr_pkg::sfr_byte_t   rd_adr;

    modport master (output wr_stb, wr_we, wr_adr, wr_dat, rd_adr);

    modport slave  (input  wr_stb, wr_we, wr_adr, wr_dat, rd_adr);

endinterface : sfr_bus_if

/* hw/sfr_core_regs.sv */
//======================================================================
// Core SFR block
// IE, IP, TMOD, TCON, INTx synchronizer and the read data mux
//======================================================================

`timescale 1ns/10ps

module sfr_core_regs (
    input  logic                clk,
    input  logic                reset_n,
    sfr_bus_if.slave            bus,
    input  logic [1:0]          intx_i,
    input  logic [1:0]          timer_ovf_i,
    input  sfr_pkg::sfr_byte_t  th_tl0_dat_i,
    input  sfr_pkg::sfr_byte_t  th_tl1_dat_i,
    output sfr_pkg::sfr_byte_t  rd_dat_o,
    output sfr_pkg::sfr_byte_t  ie_o,
    output sfr_pkg::sfr_byte_t  ip_o,
    output sfr_pkg::sfr_byte_t  tmod_o,
    output logic [1:0]          timer_run_o,
    output logic [1:0]          ext_sync_o,
    output logic [1:0]          ext_edge_o
);

    sfr_pkg::sfr_byte_t  ie_q;
    sfr_pkg::sfr_byte_t  ip_q;
    sfr_pkg::sfr_byte_t  tmod_q;
    sfr_pkg::sfr_byte_t  tcon_q;
    logic                wr_en;
    logic [1:0]          intx_meta;
    logic [1:0]          intx_sync;
    logic [1:0]          intx_prev;

    assign wr_en = bus.wr_stb && bus.wr_we;

    //==================================================================
    // Plain registers
    //==================================================================
    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            ie_q   <= '0;
            ip_q   <= '0;
            tmod_q <= '0;
        end else if (wr_en) begin
            if (bus.wr_adr == sfr_pkg::IE_ADDR)   ie_q   <= bus.wr_dat;
            if (bus.wr_adr == sfr_pkg::IP_ADDR)   ip_q   <= bus.wr_dat;
            if (bus.wr_adr == sfr_pkg::TMOD_ADDR) tmod_q <= bus.wr_dat;
        end
    end

    // TCON, bus write beats the overflow flags
    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            tcon_q <= '0;
        end else if (wr_en && (bus.wr_adr == sfr_pkg::TCON_ADDR)) begin
            tcon_q <= bus.wr_dat;
        end else begin
            // TF stays set until software clears it
            if (timer_ovf_i[0]) tcon_q[sfr_pkg::TCON_TF0_BIT] <= 1'b1;
            if (timer_ovf_i[1]) tcon_q[sfr_pkg::TCON_TF1_BIT] <= 1'b1;
        end
    end

    //==================================================================
    // INTx sync, two flops plus one for the edge
    //==================================================================
    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            intx_meta <= '0;
            intx_sync <= '0;
            intx_prev <= '0;
        end else begin
            intx_meta <= intx_i;
            intx_sync <= intx_meta;
            intx_prev <= intx_sync;
        end
    end

    assign ext_sync_o = intx_sync;
    // Rising edge, one cycle wide
    assign ext_edge_o = intx_sync & ~intx_prev;

    assign ie_o        = ie_q;
    assign ip_o        = ip_q;
    assign tmod_o      = tmod_q;
    assign timer_run_o = {tcon_q[sfr_pkg::TCON_TR1_BIT], tcon_q[sfr_pkg::TCON_TR0_BIT]};

    // Read mux, unmapped reads give 0
    always_comb begin
        case (bus.rd_adr)
            sfr_pkg::IE_ADDR:       rd_dat_o = ie_q;
            sfr_pkg::IP_ADDR:       rd_dat_o = ip_q;
            sfr_pkg::TMOD_ADDR:     rd_dat_o = tmod_q;
            sfr_pkg::TCON_ADDR:     rd_dat_o = tcon_q;
            sfr_pkg::TH0_ADDR,
            sfr_pkg::TL0_ADDR:      rd_dat_o = th_tl0_dat_i;
            sfr_pkg::TH1_ADDR,
            sfr_pkg::TL1_ADDR:      rd_dat_o = th_tl1_dat_i;
            sfr_pkg::REVISION_ADDR: rd_dat_o = sfr_pkg::MCU_REVISION;
            default:                rd_dat_o = '0;
        endcase
    end

endmodule : sfr_core_regs

/* hw/sfr_pkg.sv */
//======================================================================
// SFR package
// Bus width, SFR addresses, TCON/TMOD/IE bit positions, revision byte
//======================================================================

package sfr_pkg;

    // Data and address width of the SFR bus
    localparam int DATA_WIDTH = 8;

    typedef logic [DATA_WIDTH - 1 : 0] sfr_byte_t;

    //==================================================================
    // SFR addresses
    //==================================================================
    localparam sfr_byte_t TCON_ADDR     = 8'h88;
    localparam sfr_byte_t TMOD_ADDR     = 8'h89;
    localparam sfr_byte_t TL0_ADDR      = 8'h8A;
    localparam sfr_byte_t TL1_ADDR      = 8'h8B;
    localparam sfr_byte_t TH0_ADDR      = 8'h8C;
    localparam sfr_byte_t TH1_ADDR      = 8'h8D;
    localparam sfr_byte_t IE_ADDR       = 8'hA8;
    localparam sfr_byte_t IP_ADDR       = 8'hB8;
    localparam sfr_byte_t REVISION_ADDR = 8'hFF;

    // Read-only revision byte
    localparam sfr_byte_t MCU_REVISION = 8'h12;

    // TCON run and overflow flags
    localparam int TCON_TR0_BIT = 4;
    localparam int TCON_TF0_BIT = 5;
    localparam int TCON_TR1_BIT = 6;
    localparam int TCON_TF1_BIT = 7;

    // TMOD nibble per timer, timer 0 in the low nibble
    localparam int TMOD_FIELD_WIDTH = 4;
    localparam int TMOD_M0_BIT      = 0;
    localparam int TMOD_M1_BIT      = 1;
    localparam int TMOD_CT_BIT      = 2;
    localparam int TMOD_GATE_BIT    = 3;

    // Global interrupt enable
    localparam int IE_EA_BIT = 7;

endpackage : sfr_pkg

/* hw/timer_8051.sv */
//======================================================================
// 8051 timer
// TH/TL counter with mode 1 and mode 2, gate, C/T and overflow pulse
//======================================================================

`timescale 1ns/10ps

module timer_8051 #(
    parameter int TIMER_ID = 0
) (
    input  logic                clk,
    input  logic                reset_n,
    sfr_bus_if.slave            bus,
    input  sfr_pkg::sfr_byte_t  tmod_i,
    input  logic                run_i,
    input  logic                gate_level_i,
    input  logic                event_pulse_i,
    output sfr_pkg::sfr_byte_t  rd_dat_o,
    output logic                ovf_o,
    output logic                timer_pulse_o
);

    // Register addresses picked by timer number
    localparam sfr_pkg::sfr_byte_t TH_ADDR = (TIMER_ID == 0) ? sfr_pkg::TH0_ADDR : sfr_pkg::TH1_ADDR;
    localparam sfr_pkg::sfr_byte_t TL_ADDR = (TIMER_ID == 0) ? sfr_pkg::TL0_ADDR : sfr_pkg::TL1_ADDR;

    logic [sfr_pkg::TMOD_FIELD_WIDTH - 1 : 0]  tmod_field;
    sfr_pkg::sfr_byte_t                        th_q;
    sfr_pkg::sfr_byte_t                        tl_q;
    logic                                      mode1;
    logic                                      mode2;
    logic                                      tick;
    logic                                      wr_th;
    logic                                      wr_tl;
    logic                                      cnt_go;
    logic [16:0]                               inc16;
    logic [8:0]                                inc8;
    logic                                      wrap;

    assign tmod_field = tmod_i[TIMER_ID * sfr_pkg::TMOD_FIELD_WIDTH +: sfr_pkg::TMOD_FIELD_WIDTH];

    // M1:M0 = 01 is 16 bit, 10 is 8 bit reload, others hold
    assign mode1 = !tmod_field[sfr_pkg::TMOD_M1_BIT] && tmod_field[sfr_pkg::TMOD_M0_BIT];
    assign mode2 = tmod_field[sfr_pkg::TMOD_M1_BIT] && !tmod_field[sfr_pkg::TMOD_M0_BIT];

    // Clock or external event
    assign tick = tmod_field[sfr_pkg::TMOD_CT_BIT] ? event_pulse_i : 1'b1;

    assign wr_th = bus.wr_stb && bus.wr_we && (bus.wr_adr == TH_ADDR);
    assign wr_tl = bus.wr_stb && bus.wr_we && (bus.wr_adr == TL_ADDR);

    // Gate needs INTx high; bus writes hold the count
    assign cnt_go = run_i && tick && (mode1 || mode2) && !wr_th && !wr_tl &&
                    (!tmod_field[sfr_pkg::TMOD_GATE_BIT] || gate_level_i);

    assign inc16 = {1'b0, th_q, tl_q} + 17'd1;
    assign inc8  = {1'b0, tl_q} + 9'd1;
    assign wrap  = cnt_go && (mode1 ? inc16[16] : inc8[8]);

    //==================================================================
    // Counter
    //==================================================================
    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            th_q <= '0;
            tl_q <= '0;
        end else begin
            if (wr_th) th_q <= bus.wr_dat;
            if (wr_tl) tl_q <= bus.wr_dat;
            if (cnt_go && mode1) begin
                {th_q, tl_q} <= inc16[15:0];
            end else if (cnt_go) begin
                // Mode 2 reloads TL from TH
                tl_q <= inc8[8] ? th_q : inc8[7:0];
            end
        end
    end

    // Overflow pulse one cycle after the wrap, pin toggles after that
    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            ovf_o         <= 1'b0;
            timer_pulse_o <= 1'b0;
        end else begin
            ovf_o <= wrap;
            if (ovf_o) timer_pulse_o <= ~timer_pulse_o;
        end
    end

    always_comb begin
        if (bus.rd_adr == TH_ADDR) begin
            rd_dat_o = th_q;
        end else if (bus.rd_adr == TL_ADDR) begin
            rd_dat_o = tl_q;
        end else begin
            rd_dat_o = '0;
        end
    end

endmodule : timer_8051

/* run.sh */
#!/bin/sh
# Verilator build and run of the peripheral testbench

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_periph -f vlog.f -o sim_periph
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_periph > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Test OK$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* include/tb_check.svh */
//======================================================================
// Testbench checks
// Byte and vector compare tasks with per-test and total counters
//======================================================================

`ifndef TB_CHECK_SVH
`define TB_CHECK_SVH

int err_cnt  = 0;
int test_err = 0;
int pass_cnt = 0;
int fail_cnt = 0;

task automatic count_error();
    err_cnt++;
    test_err++;
endtask

// Read data against a range that is exact when both bounds match
task automatic check_byte(input string name, input sfr_pkg::sfr_byte_t exp_lo,
                          input sfr_pkg::sfr_byte_t exp_hi,
                          input sfr_pkg::sfr_byte_t actual);
    if ($isunknown(actual) || actual < exp_lo || actual > exp_hi) begin
        if (exp_lo == exp_hi) begin
            $display("MISMATCH %s: expected 0x%02h, actual 0x%02h", name, exp_lo, actual);
        end else begin
            $display("MISMATCH %s: expected 0x%02h..0x%02h, actual 0x%02h",
                     name, exp_lo, exp_hi, actual);
        end
        count_error();
    end
endtask

// Vector address seen with int_gen_o
task automatic check_vector(input string name, input sfr_pkg::sfr_byte_t expected,
                            input sfr_pkg::sfr_byte_t actual);
    if (actual !== expected) begin
        $display("MISMATCH %s: expected vector 0x%02h, actual 0x%02h", name, expected, actual);
        count_error();
    end
endtask

// One line per finished test
task automatic report_test(input string name);
    if (test_err == 0) begin
        pass_cnt++;
        $display("PASS  %s", name);
    end else begin
        fail_cnt++;
        $display("FAIL  %s (%0d errors)", name, test_err);
    end
    test_err = 0;
endtask

`endif

/* verif/tb_periph.sv */
//======================================================================
// Peripheral testbench
// Table driven SFR accesses, timer and interrupt checks on periph_top
//======================================================================

`timescale 1ns/10ps

module tb_periph;

    typedef enum logic [2:0] {
        OP_WRITE, OP_READ, OP_RANGE, OP_PIN, OP_INTX, OP_WAIT, OP_WAIT_INT, OP_RETURN
    } op_e;

    logic                clk;
    logic                reset_n;
    logic                rd_stb_i;
    sfr_pkg::sfr_byte_t  rd_adr_i;
    sfr_pkg::sfr_byte_t  rd_dat_o;
    logic                rd_ack_o;
    logic                wr_stb_i;
    logic                wr_we_i;
    sfr_pkg::sfr_byte_t  wr_adr_i;
    sfr_pkg::sfr_byte_t  wr_dat_i;
    logic                wr_ack_o;
    logic [1:0]          intx_i;
    logic                timer_event_pulse_i;
    logic                interrupt_return_i;
    sfr_pkg::sfr_byte_t  int_addr_o;
    logic                int_gen_o;
    logic                timer_pulse_o;

    // Stimulus table columns
    string               row_name[$];
    op_e                 row_op[$];
    sfr_pkg::sfr_byte_t  row_adr[$];
    sfr_pkg::sfr_byte_t  row_dat[$];
    sfr_pkg::sfr_byte_t  row_exp[$];

    int cycle_cnt   = 0;
    int cycle_limit = 0;

    `include "tb_check.svh"

    periph_top DUT (.*);

    always #20 clk = ~clk;

    // Run length guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, the table did not complete", cycle_cnt);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic add_row(input string name, input op_e op, input sfr_pkg::sfr_byte_t adr,
                           input sfr_pkg::sfr_byte_t dat, input sfr_pkg::sfr_byte_t exp);
        row_name.push_back(name);
        row_op.push_back(op);
        row_adr.push_back(adr);
        row_dat.push_back(dat);
        row_exp.push_back(exp);
    endtask

    //==================================================================
    // Stimulus table
    //==================================================================
    task automatic build_table();
        sfr_pkg::sfr_byte_t rnd_ie;
        sfr_pkg::sfr_byte_t rnd_ip;
        sfr_pkg::sfr_byte_t rnd_tmod;
        rnd_ie   = sfr_pkg::sfr_byte_t'($urandom);
        rnd_ip   = sfr_pkg::sfr_byte_t'($urandom);
        rnd_tmod = sfr_pkg::sfr_byte_t'($urandom);
        // Register readback, revision and unmapped space
        add_row("regs", OP_WRITE, sfr_pkg::IE_ADDR, rnd_ie, 8'h00);
        add_row("regs", OP_READ, sfr_pkg::IE_ADDR, 8'h00, rnd_ie);
        add_row("regs", OP_WRITE, sfr_pkg::IP_ADDR, rnd_ip, 8'h00);
        add_row("regs", OP_READ, sfr_pkg::IP_ADDR, 8'h00, rnd_ip);
        add_row("regs", OP_WRITE, sfr_pkg::TMOD_ADDR, rnd_tmod, 8'h00);
        add_row("regs", OP_READ, sfr_pkg::TMOD_ADDR, 8'h00, rnd_tmod);
        add_row("regs", OP_READ, sfr_pkg::REVISION_ADDR, 8'h00, 8'h12);
        add_row("regs", OP_READ, 8'h80, 8'h00, 8'h00);
        add_row("regs", OP_WRITE, sfr_pkg::IE_ADDR, 8'h00, 8'h00);
        // Timer 0 mode 1 from 0xFFF0 needs 16 counts to overflow
        add_row("mode1", OP_WRITE, sfr_pkg::TMOD_ADDR, 8'h01, 8'h00);
        add_row("mode1", OP_WRITE, sfr_pkg::TH0_ADDR, 8'hFF, 8'h00);
        add_row("mode1", OP_WRITE, sfr_pkg::TL0_ADDR, 8'hF0, 8'h00);
        add_row("mode1", OP_WRITE, sfr_pkg::TCON_ADDR, 8'h10, 8'h00);
        add_row("mode1", OP_WAIT, 8'h00, 8'd40, 8'h00);
        // TR0 and TF0
        add_row("mode1", OP_READ, sfr_pkg::TCON_ADDR, 8'h00, 8'h30);
        add_row("mode1", OP_PIN, 8'h00, 8'h00, 8'h01);
        add_row("mode1", OP_WRITE, sfr_pkg::TCON_ADDR, 8'h00, 8'h00);
        add_row("mode1", OP_READ, sfr_pkg::TCON_ADDR, 8'h00, 8'h00);
        // Timer 1 mode 2 wraps after two counts and reloads 0xC0
        add_row("mode2", OP_WRITE, sfr_pkg::TMOD_ADDR, 8'h20, 8'h00);
        add_row("mode2", OP_WRITE, sfr_pkg::TH1_ADDR, 8'hC0, 8'h00);
        add_row("mode2", OP_WRITE, sfr_pkg::TL1_ADDR, 8'hFE, 8'h00);
        add_row("mode2", OP_WRITE, sfr_pkg::TCON_ADDR, 8'h40, 8'h00);
        add_row("mode2", OP_WAIT, 8'h00, 8'd8, 8'h00);
        // TR1 and TF1
        add_row("mode2", OP_READ, sfr_pkg::TCON_ADDR, 8'h00, 8'hC0);
        add_row("mode2", OP_WRITE, sfr_pkg::TCON_ADDR, 8'h00, 8'h00);
        add_row("mode2", OP_RANGE, sfr_pkg::TL1_ADDR, 8'hC0, 8'hCA);
        add_row("mode2", OP_READ, sfr_pkg::TH1_ADDR, 8'h00, 8'hC0);
        // GATE0 with INT0 low holds timer 0
        add_row("gate", OP_WRITE, sfr_pkg::TMOD_ADDR, 8'h09, 8'h00);
        add_row("gate", OP_WRITE, sfr_pkg::TL0_ADDR, 8'h55, 8'h00);
        add_row("gate", OP_WRITE, sfr_pkg::TCON_ADDR, 8'h10, 8'h00);
        add_row("gate", OP_WAIT, 8'h00, 8'd20, 8'h00);
        add_row("gate", OP_READ, sfr_pkg::TL0_ADDR, 8'h00, 8'h55);
        add_row("gate", OP_WRITE, sfr_pkg::TCON_ADDR, 8'h00, 8'h00);
        // Both timers overflow with interrupts off before timer 1 gets high priority
        add_row("priority", OP_WRITE, sfr_pkg::TMOD_ADDR, 8'h11, 8'h00);
        add_row("priority", OP_WRITE, sfr_pkg::TH0_ADDR, 8'hFF, 8'h00);
        add_row("priority", OP_WRITE, sfr_pkg::TL0_ADDR, 8'hFE, 8'h00);
        add_row("priority", OP_WRITE, sfr_pkg::TH1_ADDR, 8'hFF, 8'h00);
        add_row("priority", OP_WRITE, sfr_pkg::TL1_ADDR, 8'hFE, 8'h00);
        add_row("priority", OP_WRITE, sfr_pkg::TCON_ADDR, 8'h50, 8'h00);
        add_row("priority", OP_WAIT, 8'h00, 8'd10, 8'h00);
        add_row("priority", OP_WRITE, sfr_pkg::TCON_ADDR, 8'h00, 8'h00);
        add_row("priority", OP_WRITE, sfr_pkg::IP_ADDR, 8'h08, 8'h00);
        // EA, ET1, ET0
        add_row("priority", OP_WRITE, sfr_pkg::IE_ADDR, 8'h8A, 8'h00);
        add_row("priority", OP_WAIT_INT, 8'h00, 8'd10, 8'h1B);
        add_row("priority", OP_RETURN, 8'h00, 8'h00, 8'h00);
        add_row("priority", OP_WAIT_INT, 8'h00, 8'd10, 8'h0B);
        add_row("priority", OP_RETURN, 8'h00, 8'h00, 8'h00);
        // EA and EX0 with a rising edge on INT0
        add_row("ext0", OP_WRITE, sfr_pkg::IE_ADDR, 8'h81, 8'h00);
        add_row("ext0", OP_INTX, 8'h00, 8'h01, 8'h00);
        add_row("ext0", OP_WAIT_INT, 8'h00, 8'd10, 8'h03);
        add_row("ext0", OP_RETURN, 8'h00, 8'h00, 8'h00);
    endtask

    //==================================================================
    // Row execution with each row starting 2 ns after a rising edge
    //==================================================================
    task automatic run_row(input int idx);
        int                 n;
        sfr_pkg::sfr_byte_t exp_lo;
        case (row_op[idx])
            OP_WRITE: begin
                wr_stb_i = 1'b1;
                wr_we_i  = 1'b1;
                wr_adr_i = row_adr[idx];
                wr_dat_i = row_dat[idx];
                #10;
                // Acknowledge follows its own strobe only
                check_byte(row_name[idx], 8'h01, 8'h01, {7'b0, wr_ack_o});
                check_byte(row_name[idx], 8'h00, 8'h00, {7'b0, rd_ack_o});
                @(posedge clk);
                #2;
                wr_stb_i = 1'b0;
                wr_we_i  = 1'b0;
            end
            OP_READ, OP_RANGE: begin
                rd_stb_i = 1'b1;
                rd_adr_i = row_adr[idx];
                // Combinational read data settles well before the edge
                #10;
                exp_lo = (row_op[idx] == OP_RANGE) ? row_dat[idx] : row_exp[idx];
                check_byte(row_name[idx], exp_lo, row_exp[idx], rd_dat_o);
                check_byte(row_name[idx], 8'h01, 8'h01, {7'b0, rd_ack_o});
                check_byte(row_name[idx], 8'h00, 8'h00, {7'b0, wr_ack_o});
                @(posedge clk);
                #2;
                rd_stb_i = 1'b0;
            end
            OP_PIN: check_byte(row_name[idx], row_exp[idx], row_exp[idx], {7'b0, timer_pulse_o});
            OP_INTX: begin
                intx_i = 2'(row_dat[idx]);
                @(posedge clk);
                #2;
            end
            OP_WAIT: begin
                repeat (row_dat[idx]) @(posedge clk);
                #2;
            end
            OP_WAIT_INT: begin
                n = 0;
                while (!int_gen_o && n < int'(row_dat[idx])) begin
                    @(posedge clk);
                    #2;
                    n++;
                end
                if (int_gen_o) begin
                    check_vector(row_name[idx], row_exp[idx], int_addr_o);
                    @(posedge clk);
                    #2;
                end else begin
                    $display("ERROR %s: no interrupt request within %0d cycles",
                             row_name[idx], row_dat[idx]);
                    count_error();
                end
            end
            default: begin
                interrupt_return_i = 1'b1;
                @(posedge clk);
                #2;
                interrupt_return_i = 1'b0;
            end
        endcase
    endtask

    initial begin
        clk                 = 1'b0;
        reset_n             = 1'b0;
        rd_stb_i            = 1'b0;
        rd_adr_i            = '0;
        wr_stb_i            = 1'b0;
        wr_we_i             = 1'b0;
        wr_adr_i            = '0;
        wr_dat_i            = '0;
        intx_i              = '0;
        timer_event_pulse_i = 1'b0;
        interrupt_return_i  = 1'b0;
        void'($urandom(98));
        build_table();

        // Sum of wait lengths plus margin
        cycle_limit = 200;
        for (int k = 0; k < row_op.size(); k++) begin
            if (row_op[k] == OP_WAIT || row_op[k] == OP_WAIT_INT) begin
                cycle_limit += int'(row_dat[k]);
            end
        end

        repeat (5) @(posedge clk);
        #2;
        reset_n = 1'b1;

        for (int i = 0; i < row_op.size(); i++) begin
            if (i > 0 && row_name[i] != row_name[i - 1]) report_test(row_name[i - 1]);
            run_row(i);
        end
        report_test(row_name[row_name.size() - 1]);

        $display("Tests %0d, passed %0d, failed %0d, errors %0d",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule : tb_periph

/* vlog.f */
+incdir+include
hw/sfr_pkg.sv
hw/int_pkg.sv
hw/sfr_bus_if.sv
hw/sfr_core_regs.sv
hw/timer_8051.sv
hw/int_ctrl.sv
hw/periph_top.sv
verif/tb_periph.sv
